/* build.f */
eeprom_pkg.sv
i2c_bit_engine.sv
eeprom_ctrl.sv
wb_eeprom_regs.sv
eeprom_top.sv
i2c_eeprom_model.sv
tb_eeprom.sv

/* eeprom_ctrl.sv */
module eeprom_ctrl
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        req_valid,
    input  eeprom_req_t req,
    input  logic        cmd_done,
    input  bit_rsp_t    bit_rsp,
    output logic        rsp_valid,
    output eeprom_rsp_t rsp,
    output logic        cmd_valid,
    output bit_cmd_t    cmd
);

    ctrl_state_t state;
    eeprom_req_t req_q;
    logic [7:0]  rdata_q;
    logic        nack_q;
    logic [7:0]  ctrl_byte_w;
    logic [7:0]  ctrl_byte_r;
    logic        byte_nacked;

    function automatic bit_cmd_t mk_cmd(bit_op_t op, logic [7:0] tx, logic last);
        bit_cmd_t c;
        c.op   = op;
        c.tx   = tx;
        c.last = last;
        return c;
    endfunction

    // block bits 10..8 travel in the control byte
    assign ctrl_byte_w = {DEV_CODE, req_q.addr[MEM_ADDR_W-1:8], 1'b0};
    assign ctrl_byte_r = {DEV_CODE, req_q.addr[MEM_ADDR_W-1:8], 1'b1};

    assign byte_nacked = cmd_done && bit_rsp.ack_error &&
                         (state inside {ST_CTRL_WRITE, ST_ADDR_WRITE, ST_DATA_WRITE,
                                        ST_CTRL_READ});

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= ST_IDLE;
            cmd_valid <= 1'b0;
            nack_q    <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            if (byte_nacked)
            begin
                nack_q    <= 1'b1;
                cmd_valid <= 1'b1;
                cmd       <= mk_cmd(BIT_STOP, 8'h00, 1'b0);
                state     <= ST_STOP;
            end
            else
            begin
                case (state)
                    ST_IDLE:
                        if (req_valid)
                        begin
                            req_q     <= req;
                            nack_q    <= 1'b0;
                            cmd_valid <= 1'b1;
                            cmd       <= mk_cmd(BIT_START, 8'h00, 1'b0);
                            state     <= ST_WRITE_START;
                        end
                    ST_WRITE_START:
                        if (cmd_done)
                        begin
                            cmd_valid <= 1'b1;
                            cmd       <= mk_cmd(BIT_WRITE, ctrl_byte_w, 1'b0);
                            state     <= ST_CTRL_WRITE;
                        end
                    ST_CTRL_WRITE:
                        if (cmd_done)
                        begin
                            cmd_valid <= 1'b1;
                            cmd       <= mk_cmd(BIT_WRITE, req_q.addr[7:0], 1'b0);
                            state     <= ST_ADDR_WRITE;
                        end
                    ST_ADDR_WRITE:
                        if (cmd_done)
                        begin
                            cmd_valid <= 1'b1;
                            if (req_q.op == OP_WRITE)
                            begin
                                cmd   <= mk_cmd(BIT_WRITE, req_q.wdata, 1'b0);
                                state <= ST_DATA_WRITE;
                            end
                            else
                            begin
                                cmd   <= mk_cmd(BIT_START, 8'h00, 1'b0);    // repeated start
                                state <= ST_READ_START;
                            end
                        end
                    ST_READ_START:
                        if (cmd_done)
                        begin
                            cmd_valid <= 1'b1;
                            cmd       <= mk_cmd(BIT_WRITE, ctrl_byte_r, 1'b0);
                            state     <= ST_CTRL_READ;
                        end
                    ST_CTRL_READ:
                        if (cmd_done)
                        begin
                            cmd_valid <= 1'b1;
                            cmd       <= mk_cmd(BIT_READ, 8'h00, 1'b1);    // single byte gets nack
                            state     <= ST_DATA_READ;
                        end
                    ST_DATA_WRITE, ST_DATA_READ:
                        if (cmd_done)
                        begin
                            if (state == ST_DATA_READ)
                                rdata_q <= bit_rsp.rx;
                            cmd_valid <= 1'b1;
                            cmd       <= mk_cmd(BIT_STOP, 8'h00, 1'b0);
                            state     <= ST_STOP;
                        end
                    ST_STOP:
                        if (cmd_done)
                            state <= ST_DONE;
                    ST_DONE:
                        state <= ST_IDLE;
                    default:
                        state <= ST_IDLE;
                endcase
            end
        end
    end

    assign rsp_valid = (state == ST_DONE);
    assign rsp       = '{rdata: rdata_q, nack: nack_q};

    assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> !(state inside {ST_IDLE, ST_DONE}));

    // register block must hold off while a transfer runs
    assert property (@(posedge CLK) disable iff (RESET)
        req_valid |-> state == ST_IDLE);

endmodule

/* eeprom_pkg.sv */
package eeprom_pkg;

    localparam int MEM_ADDR_W = 11;    // 2 KB array
    localparam int WB_ADDR_W  = 2;
    localparam int WB_DATA_W  = 32;

    // device type code in the upper nibble of the control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // scl runs at CLK / PHASES_PER_BIT
    localparam int PHASES_PER_BIT = 4;
    localparam int PHASE_W        = $clog2(PHASES_PER_BIT);
    localparam logic [PHASE_W-1:0] SAMPLE_PHASE = PHASE_W'(PHASES_PER_BIT - 2);
    localparam logic [PHASE_W-1:0] LAST_PHASE   = PHASE_W'(PHASES_PER_BIT - 1);
    localparam int BIT_CNT_W = 4;
    localparam logic [BIT_CNT_W-1:0] ACK_BIT = 4'd8;    // ninth bit of a byte

    // wishbone register map
    localparam logic [WB_ADDR_W-1:0] REG_ADDR = 2'd0;
    localparam logic [WB_ADDR_W-1:0] REG_DATA = 2'd1;
    localparam logic [WB_ADDR_W-1:0] REG_CMD  = 2'd2;

    typedef enum logic {OP_WRITE, OP_READ} eeprom_op_t;

    typedef enum logic [1:0] {BIT_START, BIT_STOP, BIT_WRITE, BIT_READ} bit_op_t;

    typedef enum logic [3:0] {
        ST_IDLE, ST_WRITE_START, ST_CTRL_WRITE, ST_ADDR_WRITE, ST_DATA_WRITE,
        ST_READ_START, ST_CTRL_READ, ST_DATA_READ, ST_STOP, ST_DONE
    } ctrl_state_t;

    typedef struct packed {
        eeprom_op_t            op;
        logic [MEM_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;
    } eeprom_rsp_t;

    // last set means answer the read byte with a no-acknowledge
    typedef struct packed {
        bit_op_t    op;
        logic [7:0] tx;
        logic       last;
    } bit_cmd_t;

    typedef struct packed {
        logic [7:0] rx;
        logic       ack_error;
    } bit_rsp_t;

endpackage

/* eeprom_top.sv */
module eeprom_top
    import eeprom_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic [WB_ADDR_W-1:0] wb_adr,
    input  logic [WB_DATA_W-1:0] wb_dat_w,
    output logic [WB_DATA_W-1:0] wb_dat_r,
    input  logic                 wb_we,
    input  logic                 wb_stb,
    input  logic                 wb_cyc,
    output logic                 wb_ack,
    output logic                 scl,
    output logic                 sda_oe,    // high pulls sda low
    input  logic                 sda_in
);

    logic        req_valid;
    eeprom_req_t req;
    logic        rsp_valid;
    eeprom_rsp_t rsp;
    logic        cmd_valid;
    bit_cmd_t    cmd;
    logic        cmd_done;
    bit_rsp_t    bit_rsp;

    wb_eeprom_regs regs_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_we     (wb_we),
        .wb_stb    (wb_stb),
        .wb_cyc    (wb_cyc),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .req_valid (req_valid),
        .req       (req)
    );

    eeprom_ctrl ctrl_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .cmd_done  (cmd_done),
        .bit_rsp   (bit_rsp),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    i2c_bit_engine engine_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .sda_in    (sda_in),
        .cmd_done  (cmd_done),
        .rsp       (bit_rsp),
        .scl       (scl),
        .sda_oe    (sda_oe)
    );

endmodule

/* i2c_bit_engine.sv */
module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     cmd_valid,
    input  bit_cmd_t cmd,
    input  logic     sda_in,
    output logic     cmd_done,
    output bit_rsp_t rsp,
    output logic     scl,
    output logic     sda_oe
);

    logic                 active;
    logic [PHASE_W-1:0]   phase;
    logic [BIT_CNT_W-1:0] bit_cnt;
    bit_op_t              op_q;
    logic [7:0]           tx_q;
    logic                 last_q;
    logic [7:0]           rx_q;
    logic                 ack_err_q;

    logic [PHASE_W-1:0]   next_phase;
    logic [BIT_CNT_W-1:0] next_bit;
    logic [BIT_CNT_W-1:0] final_bit;
    logic [1:0]           next_level;

    // {scl, sda_oe} for one phase of one bit
    function automatic logic [1:0] bus_level(
        bit_op_t              op,
        logic [BIT_CNT_W-1:0] bit_idx,
        logic [PHASE_W-1:0]   ph,
        logic [7:0]           tx,
        logic                 last
    );
        logic scl_l;
        logic oe_l;
        scl_l = (ph != '0) && (ph != LAST_PHASE);
        oe_l  = 1'b0;
        case (op)
            BIT_START:
                oe_l = (ph >= SAMPLE_PHASE);    // sda falls under high scl
            BIT_STOP:
            begin
                scl_l = (ph != '0);
                oe_l  = (ph < SAMPLE_PHASE);    // sda released under high scl
            end
            BIT_WRITE:
                oe_l = (bit_idx < ACK_BIT) ? !tx[3'd7 - bit_idx[2:0]] : 1'b0;
            BIT_READ:
                oe_l = (bit_idx == ACK_BIT) ? !last : 1'b0;
            default:
                oe_l = 1'b0;
        endcase
        return {scl_l, oe_l};
    endfunction

    always_comb
    begin
        next_phase = phase + 1'b1;
        next_bit   = (phase == LAST_PHASE) ? bit_cnt + 1'b1 : bit_cnt;
        final_bit  = (op_q == BIT_WRITE || op_q == BIT_READ) ? ACK_BIT : '0;
        next_level = bus_level(op_q, next_bit, next_phase, tx_q, last_q);
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            phase    <= '0;
            bit_cnt  <= '0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
            cmd_done <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (!active)
            begin
                if (cmd_valid)
                begin
                    active        <= 1'b1;
                    phase         <= '0;
                    bit_cnt       <= '0;
                    {scl, sda_oe} <= bus_level(cmd.op, '0, '0, cmd.tx, cmd.last);
                end
            end
            else if (phase == LAST_PHASE && bit_cnt == final_bit)
            begin
                active <= 1'b0;    // lines hold their level until next command
            end
            else
            begin
                phase         <= next_phase;
                bit_cnt       <= next_bit;
                {scl, sda_oe} <= next_level;
                if (phase == SAMPLE_PHASE && bit_cnt == final_bit)
                    cmd_done <= 1'b1;
            end
        end
    end

    // command payload and sampled data
    always_ff @(posedge CLK)
    begin
        if (!active && cmd_valid)
        begin
            op_q      <= cmd.op;
            tx_q      <= cmd.tx;
            last_q    <= cmd.last;
            ack_err_q <= 1'b0;
        end
        else if (active && phase == SAMPLE_PHASE)
        begin
            if (op_q == BIT_READ && bit_cnt < ACK_BIT)
                rx_q <= {rx_q[6:0], sda_in};    // msb first
            if (op_q == BIT_WRITE && bit_cnt == ACK_BIT)
                ack_err_q <= sda_in;    // high means no acknowledge
        end
    end

    assign rsp = '{rx: rx_q, ack_error: ack_err_q};

    // data moves only while scl stays low except in start and stop
    assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_oe) && !(op_q inside {BIT_START, BIT_STOP}) |-> !scl && !$past(scl));

endmodule

/* i2c_eeprom_model.sv */
module i2c_eeprom_model
    import eeprom_pkg::*;
(
    input  logic scl,
    input  logic sda,
    input  logic busy,      // internal write cycle withholds acknowledges
    output logic sda_oe     // 1 pulls sda low
);

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_ADDR, M_DATA, M_SEND} model_state_t;

    logic [7:0]            mem [0:(1 << MEM_ADDR_W)-1];
    model_state_t          state;
    logic [3:0]            bit_cnt;     // bits clocked in the current byte
    logic [7:0]            sr;
    logic [7:0]            tx;
    logic [2:0]            blk;
    logic [MEM_ADDR_W-1:0] addr;
    logic                  master_nack;
    logic                  ack;

    initial
    begin
        state       = M_IDLE;
        sda_oe      = 1'b0;
        bit_cnt     = '0;
        master_nack = 1'b0;
        for (int i = 0; i < (1 << MEM_ADDR_W); i++)
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5c;
    end

    // start or repeated start
    always @(negedge sda)
        if (scl === 1'b1)
        begin
            state   = M_CTRL;
            bit_cnt = '0;
            sda_oe  = 1'b0;
        end

    always @(posedge sda)
        if (scl === 1'b1)
            state = M_IDLE;    // stop

    always @(posedge scl)
        if (state != M_IDLE)
        begin
            if (bit_cnt < 4'd8)
            begin
                sr      = {sr[6:0], sda};
                bit_cnt = bit_cnt + 1'b1;
            end
            else
            begin
                master_nack = sda;    // only looked at while sending
                bit_cnt     = 4'd9;
            end
        end

    always @(negedge scl)
        if (state != M_IDLE)
        begin
            if (bit_cnt == 4'd8 && state == M_SEND)
                sda_oe = 1'b0;    // let the master answer
            else if (bit_cnt == 4'd8)
            begin
                ack    = !busy && (state != M_CTRL || sr[7:4] == DEV_CODE);
                sda_oe = ack;
                if (!ack)
                    state = M_IDLE;
                else if (state == M_CTRL)
                begin
                    blk         = sr[3:1];
                    master_nack = 1'b0;
                    if (sr[0])
                    begin
                        addr  = {sr[3:1], addr[7:0]};
                        state = M_SEND;
                    end
                    else
                        state = M_ADDR;
                end
                else if (state == M_ADDR)
                begin
                    addr  = {blk, sr};
                    state = M_DATA;
                end
                else
                begin
                    mem[addr] = sr;
                    addr      = addr + 1'b1;
                end
            end
            else if (bit_cnt == 4'd9)
            begin
                sda_oe  = 1'b0;
                bit_cnt = '0;
                if (state == M_SEND && master_nack)
                    state = M_IDLE;
                else if (state == M_SEND)
                begin
                    tx     = mem[addr];
                    addr   = addr + 1'b1;
                    sda_oe = !tx[7];
                end
            end
            else if (state == M_SEND && bit_cnt != '0)
                sda_oe = !tx[7 - bit_cnt];    // msb first
        end

endmodule

/* tb_eeprom.sv */
module tb_eeprom
    import eeprom_pkg::*;
();

    logic                 CLK;
    logic                 RESET;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_w;
    logic [WB_DATA_W-1:0] wb_dat_r;
    logic                 wb_we;
    logic                 wb_stb;
    logic                 wb_cyc;
    logic                 wb_ack;
    logic                 scl;
    logic                 sda_oe;
    logic                 model_sda_oe;
    logic                 model_busy;
    wire                  sda;
    integer               seed;
    int                   ack_wait;    // edges from strobe to seen ack

    assign sda = !(sda_oe || model_sda_oe);    // open drain with pull-up

    eeprom_top eeprom_top_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_we    (wb_we),
        .wb_stb   (wb_stb),
        .wb_cyc   (wb_cyc),
        .wb_ack   (wb_ack),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda)
    );

    i2c_eeprom_model eeprom_model_i (
        .scl    (scl),
        .sda    (sda),
        .busy   (model_busy),
        .sda_oe (model_sda_oe)
    );

    initial
        CLK = 1'b0;

    always #50 CLK = !CLK;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                                $time, msg, got, exp));
    endtask

    task automatic wb_transfer(input logic we, input logic [WB_ADDR_W-1:0] adr,
                               input logic [WB_DATA_W-1:0] wdat,
                               output logic [WB_DATA_W-1:0] rdat);
        int n;
        @(posedge CLK);
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        wb_we    <= we;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        n = 0;
        do
        begin
            @(posedge CLK);
            n++;
            if (n > 16)
                abort_run("wishbone slave gave no ack within 16 cycles");
        end
        while (!wb_ack);
        rdat     = wb_dat_r;
        ack_wait = n;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] dat);
        logic [WB_DATA_W-1:0] unused;
        wb_transfer(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [WB_DATA_W-1:0] dat);
        wb_transfer(1'b0, adr, '0, dat);
    endtask

    task automatic wait_idle(output logic [WB_DATA_W-1:0] status);
        int polls;
        polls = 0;
        do
        begin
            wb_read(REG_CMD, status);
            polls++;
            if (polls > 400)
                abort_run("busy bit still set after 400 status reads");
        end
        while (status[0]);
    endtask

    task automatic store_byte(input logic [10:0] addr, input logic [7:0] data, input logic nack);
        logic [WB_DATA_W-1:0] status;
        wb_write(REG_ADDR, 32'(addr));
        wb_write(REG_DATA, 32'(data));
        wb_write(REG_CMD, 32'h1);
        wait_idle(status);
        check(status[1], nack, "nack flag after write transfer");
    endtask

    task automatic fetch_byte(input logic [10:0] addr, output logic [7:0] data);
        logic [WB_DATA_W-1:0] status;
        logic [WB_DATA_W-1:0] rd;
        wb_write(REG_ADDR, 32'(addr));
        wb_write(REG_CMD, 32'h2);
        wait_idle(status);
        check(status[1], 1'b0, "nack flag after read transfer");
        wb_read(REG_DATA, rd);
        data = rd[7:0];
    endtask

    task automatic after_reset();
        logic [WB_DATA_W-1:0] d;
        check(scl, 1'b1, "scl idles high");
        check(sda_oe, 1'b0, "sda released after reset");
        wb_read(REG_CMD, d);
        check(d, 32'h0, "busy and nack after reset");
    endtask

    task automatic register_readback();
        logic [WB_DATA_W-1:0] d;
        wb_write(REG_ADDR, 32'hffff_f5a3);
        check(ack_wait, 2, "ack one cycle after strobe");
        @(posedge CLK);
        check(wb_ack, 1'b0, "ack lasts a single cycle");
        wb_write(REG_DATA, 32'h1234_56c9);
        wb_read(REG_ADDR, d);
        check(ack_wait, 2, "read ack one cycle after strobe");
        check(d, 32'h0000_05a3, "address register masked to 11 bits");
        wb_read(REG_DATA, d);
        check(d, 32'h0000_00c9, "data register masked to 8 bits");
    endtask

    task automatic write_then_read();
        logic [7:0] data;
        logic [7:0] got;
        data = $random(seed);
        store_byte(11'h2b7, data, 1'b0);
        wb_write(REG_DATA, 32'(~data));    // stale byte must be replaced by the read
        fetch_byte(11'h2b7, got);
        check(got, data, "byte read back from 0x2b7");
    endtask

    // same low byte in every block, so a lost block bit shows up
    task automatic block_bit_coverage();
        logic [7:0] lo;
        logic [7:0] base;
        logic [7:0] got;
        int         j;
        lo   = $random(seed);
        base = $random(seed);
        for (int k = 0; k < 8; k++)
            store_byte({3'(k), lo}, base + 8'(k * 29), 1'b0);
        for (int k = 0; k < 8; k++)
        begin
            j = (k * 3 + 1) % 8;
            fetch_byte({3'(j), lo}, got);
            check(got, 8'(base + j * 29), $sformatf("byte from block %0d", j));
        end
    endtask

    task automatic busy_device_nack();
        logic [7:0] data;
        logic [7:0] got;
        data = $random(seed);
        store_byte(11'h64e, data, 1'b0);
        @(posedge CLK);
        model_busy <= 1'b1;
        store_byte(11'h64e, ~data, 1'b1);
        @(posedge CLK);
        model_busy <= 1'b0;
        fetch_byte(11'h64e, got);
        check(got, data, "refused write left memory unchanged");
    endtask

    task automatic command_while_busy();
        logic [WB_DATA_W-1:0] status;
        logic [7:0]           first_data;
        logic [7:0]           old_data;
        logic [7:0]           got;
        first_data = $random(seed);
        old_data   = $random(seed);
        store_byte(11'h3d8, old_data, 1'b0);
        wb_write(REG_ADDR, 32'h1c3);
        wb_write(REG_DATA, 32'(first_data));
        wb_write(REG_CMD, 32'h1);
        wb_write(REG_ADDR, 32'h3d8);
        wb_write(REG_DATA, 32'(~old_data));
        wb_write(REG_CMD, 32'h1);    // lands mid transfer
        wb_read(REG_CMD, status);
        check(status[0], 1'b1, "busy during first transfer");
        wait_idle(status);
        for (int k = 0; k < 80; k++)
        begin
            wb_read(REG_CMD, status);
            check(status[0], 1'b0, "busy stays low after the transfer");
        end
        fetch_byte(11'h1c3, got);
        check(got, first_data, "first command took effect");
        fetch_byte(11'h3d8, got);
        check(got, old_data, "second command was ignored");
    endtask

    initial
    begin
        seed       = 32'h71e85013;
        RESET      = 1'b1;
        wb_adr     = '0;
        wb_dat_w   = '0;
        wb_we      = 1'b0;
        wb_stb     = 1'b0;
        wb_cyc     = 1'b0;
        model_busy = 1'b0;
        repeat (3) @(posedge CLK);
        RESET <= 1'b0;
        after_reset();
        register_readback();
        write_then_read();
        block_bit_coverage();
        busy_device_nack();
        command_while_busy();
        $display("Testbench passed");
        $finish;
    end

endmodule

/* wb_eeprom_regs.sv */
module wb_eeprom_regs
    import eeprom_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic [WB_ADDR_W-1:0] wb_adr,
    input  logic [WB_DATA_W-1:0] wb_dat_w,
    input  logic                 wb_we,
    input  logic                 wb_stb,
    input  logic                 wb_cyc,
    input  logic                 rsp_valid,
    input  eeprom_rsp_t          rsp,
    output logic [WB_DATA_W-1:0] wb_dat_r,
    output logic                 wb_ack,
    output logic                 req_valid,
    output eeprom_req_t          req
);

    logic [MEM_ADDR_W-1:0] addr_q;
    logic [7:0]            data_q;    // wdata going out, read byte coming back
    logic                  busy;
    logic                  nack;
    logic                  wr_stb;
    logic                  cmd_go;

    assign wr_stb = wb_cyc && wb_stb && wb_we && !wb_ack;
    assign cmd_go = wr_stb && (wb_adr == REG_CMD) && !busy && (wb_dat_w[0] || wb_dat_w[1]);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wb_ack    <= 1'b0;
            req_valid <= 1'b0;
            busy      <= 1'b0;
            nack      <= 1'b0;
        end
        else
        begin
            wb_ack    <= wb_cyc && wb_stb && !wb_ack;    // one cycle per access
            req_valid <= 1'b0;
            if (rsp_valid)
            begin
                busy <= 1'b0;
                nack <= rsp.nack;
            end
            if (cmd_go)
            begin
                req_valid <= 1'b1;
                busy      <= 1'b1;
                nack      <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (wr_stb && wb_adr == REG_ADDR)
            addr_q <= wb_dat_w[MEM_ADDR_W-1:0];
        if (wr_stb && wb_adr == REG_DATA)
            data_q <= wb_dat_w[7:0];
        else if (rsp_valid && req.op == OP_READ)
            data_q <= rsp.rdata;
        if (cmd_go)
        begin
            req.op    <= wb_dat_w[0] ? OP_WRITE : OP_READ;    // write wins
            req.addr  <= addr_q;
            req.wdata <= data_q;
        end
    end

    always_comb
    begin
        case (wb_adr)
            REG_ADDR: wb_dat_r = WB_DATA_W'(addr_q);
            REG_DATA: wb_dat_r = WB_DATA_W'(data_q);
            REG_CMD:  wb_dat_r = WB_DATA_W'({nack, busy});
            default:  wb_dat_r = '0;
        endcase
    end

    assert property (@(posedge CLK) disable iff (RESET)
        wb_ack |-> wb_stb && wb_cyc);

endmodule
